// ==== rtl/dma_arb_pkg.sv ====
// shared types and constants for the chip-bus DMA arbiter, imported by every RTL block
package dma_arb_pkg;

  // --------------------
  // basic widths
  // --------------------
  typedef logic [15:0] word_t;      // custom chip data word
  typedef logic [19:0] chip_addr_t; // chip memory word address
  typedef logic [7:0]  reg_addr_t;  // custom register word address (256 words)
  typedef logic [8:0]  slot_t;      // horizontal slot index

  // --------------------
  // register map (word addresses)
  // --------------------
  localparam reg_addr_t REG_IDLE    = 8'hFF; // nothing selected on the register bus
  localparam reg_addr_t REG_DMACON  = 8'h4B; // byte address 0x096
  localparam reg_addr_t REG_DMACONR = 8'h01; // byte address 0x002

  // dma control register layout
  localparam int DMACON_SETCLR = 15; // 1 = set written bits, 0 = clear them
  localparam int DMACON_BITS   = 13; // stored width
  localparam int BLTPRI        = 10; // blitter nasty
  localparam int DMAEN         = 9;  // master enable
  localparam int BPLEN         = 8;
  localparam int COPEN         = 7;
  localparam int BLTEN         = 6;
  localparam int SPREN         = 5;

  // --------------------
  // line timing
  // --------------------
  localparam int    LINE_SLOTS     = 454;   // slots per line
  localparam slot_t REFRESH_SLOT_0 = 9'd5;  // fixed memory refresh slots
  localparam slot_t REFRESH_SLOT_1 = 9'd9;
  localparam slot_t REFRESH_SLOT_2 = 9'd13;
  localparam slot_t REFRESH_SLOT_3 = 9'd17;

  // blitter is blocked once the cpu has missed the bus this many times
  localparam logic [1:0] BLS_MAX = 2'd3;

  // bus owner, listed in priority order
  typedef enum logic [2:0] {
    OWN_DISK, OWN_REFRESH, OWN_AUDIO, OWN_BITPLANE,
    OWN_SPRITE, OWN_COPPER, OWN_BLITTER, OWN_CPU
  } owner_t;

  // one dma engine's request to the arbiter
  typedef struct packed {
    logic       req;
    chip_addr_t chip_addr;
    reg_addr_t  reg_addr;
    logic       wr;        // memory write, honoured for disk and blitter only
  } dma_chan_t;

  // cpu register access strobes
  typedef struct packed {
    logic      aen;  // register bank select
    logic      rd;
    logic      hwr;
    logic      lwr;
    reg_addr_t addr;
  } cpu_bus_t;

  // gated channel enables out of dmacon
  typedef struct packed {
    logic bitplane;
    logic sprite;
    logic copper;
    logic blitter;
    logic bltpri;
  } chan_en_t;

  // arbiter result driven onto the chip and register buses
  typedef struct packed {
    chip_addr_t chip_addr;
    reg_addr_t  reg_addr;
    logic       dbr;        // agnus owns the data bus
    logic       dbwe;       // dma memory write
    logic       cpu_custom; // cpu owns chip memory and registers
  } bus_grant_t;

endpackage

// ==== rtl/beam_slot_counter.sv ====
// horizontal beam slot counter; feeds the arbiter with the slot, the refresh slots and cck
`timescale 1ns/100ps

module beam_slot_counter
  import dma_arb_pkg::*;
(
  input  logic  clk,
  input  logic  reset,
  output slot_t slot,    // current bus slot in the line
  output logic  refresh, // memory refresh owns this slot
  output logic  cck      // colour clock phase, odd slots
);

  localparam slot_t LAST_SLOT = slot_t'(LINE_SLOTS - 1);

  // --------------------
  // slot counter
  // --------------------
  // one clk is one bus slot, wraps at end of line
  always_ff @(posedge clk) begin
    if (reset) begin
      slot <= '0;
    end else if (slot == LAST_SLOT) begin
      slot <= '0; // start of next line
    end else begin
      slot <= slot + 9'd1;
    end
  end

  // --------------------
  // slot decode
  // --------------------
  // four fixed refresh slots at the start of each line
  always_comb begin
    refresh = (slot == REFRESH_SLOT_0) ||
              (slot == REFRESH_SLOT_1) ||
              (slot == REFRESH_SLOT_2) ||
              (slot == REFRESH_SLOT_3);
  end

  // chipset uses the odd slots, cpu gets the even ones
  assign cck = slot[0];

endmodule

// ==== rtl/dma_control_reg.sv ====
// dmacon set/clear register with dmaconr status read; supplies the channel enables
`timescale 1ns/100ps

module dma_control_reg
  import dma_arb_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  reg_addr_t reg_addr,  // register bus from the arbiter
  input  word_t     data_in,
  input  logic      blit_busy, // blitter status for the read word
  input  logic      blit_zero,
  output chan_en_t  chan_en,
  output word_t     data_out   // zero unless dmaconr is addressed
);

  logic [DMACON_BITS-1:0] dmacon; // stored control bits
  logic                   wr_sel; // dmacon addressed this slot
  logic                   rd_sel; // dmaconr addressed this slot

  assign wr_sel = (reg_addr == REG_DMACON);
  assign rd_sel = (reg_addr == REG_DMACONR);

  // --------------------
  // control write
  // --------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      dmacon <= '0;
    end else if (wr_sel) begin
      if (data_in[DMACON_SETCLR]) begin
        dmacon <= dmacon | data_in[DMACON_BITS-1:0];  // set the ones written
      end else begin
        dmacon <= dmacon & ~data_in[DMACON_BITS-1:0]; // clear the ones written
      end
    end
  end

  // --------------------
  // status read
  // --------------------
  // top bit reads as 0, then busy, zero and the stored bits
  always_comb begin
    if (rd_sel) begin
      data_out = {1'b0, blit_busy, blit_zero, dmacon};
    end else begin
      data_out = '0;
    end
  end

  // --------------------
  // channel enables
  // --------------------
  // each gated channel also needs the master enable
  always_comb begin
    chan_en.bitplane = dmacon[BPLEN] & dmacon[DMAEN];
    chan_en.sprite   = dmacon[SPREN] & dmacon[DMAEN];
    chan_en.copper   = dmacon[COPEN] & dmacon[DMAEN];
    chan_en.blitter  = dmacon[BLTEN] & dmacon[DMAEN];
    chan_en.bltpri   = dmacon[BLTPRI]; // nasty bit is not masked
  end

endmodule

// ==== rtl/bus_arbiter.sv ====
// fixed-priority chip bus arbiter with blitter slowdown; picks the slot owner every clk
`timescale 1ns/100ps

module bus_arbiter
  import dma_arb_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  slot_t      slot,
  input  logic       refresh,      // refresh slot flag
  input  logic       cck,          // odd slot
  input  chan_en_t   chan_en,
  input  dma_chan_t  disk,
  input  dma_chan_t  audio,
  input  dma_chan_t  bitplane,
  input  dma_chan_t  sprite,
  input  dma_chan_t  copper,
  input  dma_chan_t  blitter,
  input  reg_addr_t  cpu_reg_addr, // already REG_IDLE when no strobe
  input  logic       bls,          // cpu missed the bus
  output bus_grant_t grant,
  output owner_t     owner,
  output logic       ack_sprite,
  output logic       ack_copper,
  output logic       ack_blitter
);

  logic [1:0] bls_cnt;     // slots in a row the cpu lost the bus
  logic       blt_blocked; // slowdown limit reached

  // --------------------
  // blitter slowdown
  // --------------------
  // only counted at the end of cpu (even) slots
  always_ff @(posedge clk) begin
    if (reset) begin
      bls_cnt <= '0;
    end else if (!cck) begin
      if (!bls || chan_en.bltpri) begin
        bls_cnt <= '0;             // cpu got through, or blitter has priority
      end else if (bls_cnt != BLS_MAX) begin
        bls_cnt <= bls_cnt + 2'd1; // saturate at the limit
      end
    end
  end

  assign blt_blocked = (bls_cnt == BLS_MAX);

  // --------------------
  // priority select
  // --------------------
  // first match wins in the order disk, refresh, audio, bitplane, sprite, copper, blitter
  always_comb begin
    if (disk.req)                                      owner = OWN_DISK;
    else if (refresh)                                  owner = OWN_REFRESH;
    else if (audio.req)                                owner = OWN_AUDIO;
    else if (bitplane.req && chan_en.bitplane)         owner = OWN_BITPLANE;
    else if (sprite.req && chan_en.sprite)             owner = OWN_SPRITE;
    else if (copper.req && chan_en.copper)             owner = OWN_COPPER;
    else if (blitter.req && chan_en.blitter && !blt_blocked) owner = OWN_BLITTER;
    else                                               owner = OWN_CPU;
  end

  // acks follow the owner, so at most one is high
  assign ack_sprite  = (owner == OWN_SPRITE);
  assign ack_copper  = (owner == OWN_COPPER);
  assign ack_blitter = (owner == OWN_BLITTER);

  // --------------------
  // bus mux
  // --------------------
  always_comb begin
    grant.chip_addr  = '0;
    grant.reg_addr   = REG_IDLE;
    grant.dbr        = 1'b1; // any dma owner takes the data bus
    grant.dbwe       = 1'b0;
    grant.cpu_custom = 1'b0;
    case (owner)
      OWN_DISK: begin
        grant.chip_addr = disk.chip_addr;
        grant.reg_addr  = disk.reg_addr;
        grant.dbwe      = disk.wr;     // disk may write memory
      end
      OWN_REFRESH: begin
        // address zero and no register come from the defaults
      end
      OWN_AUDIO: begin
        grant.chip_addr = audio.chip_addr;
        grant.reg_addr  = audio.reg_addr;
      end
      OWN_BITPLANE: begin
        grant.chip_addr = bitplane.chip_addr;
        grant.reg_addr  = bitplane.reg_addr;
      end
      OWN_SPRITE: begin
        grant.chip_addr = sprite.chip_addr;
        grant.reg_addr  = sprite.reg_addr;
      end
      OWN_COPPER: begin
        grant.chip_addr = copper.chip_addr;
        grant.reg_addr  = copper.reg_addr;
      end
      OWN_BLITTER: begin
        grant.chip_addr = blitter.chip_addr;
        grant.reg_addr  = blitter.reg_addr;
        grant.dbwe      = blitter.wr;  // blitter d channel write
      end
      default: begin
        // cpu slot where the register bus carries the cpu address
        grant.reg_addr   = cpu_reg_addr;
        grant.dbr        = 1'b0;
        grant.cpu_custom = 1'b1;
      end
    endcase
  end

endmodule

// ==== rtl/agnus_dma.sv ====
// top of the dma slot arbiter; decodes the cpu register access and joins counter, dmacon, arbiter
`timescale 1ns/100ps

module agnus_dma
  import dma_arb_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  cpu_bus_t   cpu,        // cpu register strobes and address
  input  word_t      data_in,
  input  dma_chan_t  disk,       // engine requests, highest priority first
  input  dma_chan_t  audio,
  input  dma_chan_t  bitplane,
  input  dma_chan_t  sprite,
  input  dma_chan_t  copper,
  input  dma_chan_t  blitter,
  input  logic       blit_busy,
  input  logic       blit_zero,
  input  logic       bls,        // cpu missed the bus
  output bus_grant_t grant,
  output owner_t     owner,
  output logic       ack_sprite,
  output logic       ack_copper,
  output logic       ack_blitter,
  output word_t      data_out,
  output slot_t      slot
);

  logic      refresh;      // refresh slot flag
  logic      cck;          // colour clock phase
  chan_en_t  chan_en;      // enables from dmacon
  reg_addr_t cpu_reg_addr; // decoded cpu register address

  // --------------------
  // cpu address decode
  // --------------------
  // register address only with bank select and a strobe
  assign cpu_reg_addr = (cpu.aen && (cpu.rd || cpu.hwr || cpu.lwr)) ? cpu.addr : REG_IDLE;

  beam_slot_counter u_slot (
    .clk     (clk),
    .reset   (reset),
    .slot    (slot),
    .refresh (refresh),
    .cck     (cck)
  );

  // decodes the arbitrated register bus, not the raw cpu address
  dma_control_reg u_dmacon (
    .clk       (clk),
    .reset     (reset),
    .reg_addr  (grant.reg_addr),
    .data_in   (data_in),
    .blit_busy (blit_busy),
    .blit_zero (blit_zero),
    .chan_en   (chan_en),
    .data_out  (data_out)
  );

  bus_arbiter u_arb (
    .clk          (clk),
    .reset        (reset),
    .slot         (slot),
    .refresh      (refresh),
    .cck          (cck),
    .chan_en      (chan_en),
    .disk         (disk),
    .audio        (audio),
    .bitplane     (bitplane),
    .sprite       (sprite),
    .copper       (copper),
    .blitter      (blitter),
    .cpu_reg_addr (cpu_reg_addr),
    .bls          (bls),
    .grant        (grant),
    .owner        (owner),
    .ack_sprite   (ack_sprite),
    .ack_copper   (ack_copper),
    .ack_blitter  (ack_blitter)
  );

endmodule

// ==== verification/tb_model.svh ====
// reference model and compare tasks for the dma arbiter testbench, included in the tb top module
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// --------------------
// model state
// --------------------
slot_t       m_slot;    // expected beam slot
logic [12:0] m_dmacon;  // expected control register
logic [1:0]  m_bls_cnt; // expected slowdown count

bus_grant_t exp_grant;  // expected outputs of the current cycle
owner_t     exp_owner;
word_t      exp_data;

int grant_errs;
int owner_errs;
int ack_errs;
int data_errs;
int slot_errs;

task automatic model_reset();
  m_slot    = '0;
  m_dmacon  = '0;
  m_bls_cnt = '0;
endtask

// expected bus result from the current inputs and the model state
task automatic model_outputs();
  logic      ref_slot;
  logic      blocked;
  reg_addr_t cpu_ra;
  dma_chan_t src;
  ref_slot = (m_slot == 9'd5) || (m_slot == 9'd9) || (m_slot == 9'd13) || (m_slot == 9'd17);
  blocked  = (m_bls_cnt == 2'd3);
  cpu_ra   = (cpu.aen && (cpu.rd || cpu.hwr || cpu.lwr)) ? cpu.addr : REG_IDLE;
  // priority chain, gated channels need their bit and the master enable
  if (disk.req) exp_owner = OWN_DISK;
  else if (ref_slot) exp_owner = OWN_REFRESH;
  else if (audio.req) exp_owner = OWN_AUDIO;
  else if (bitplane.req && m_dmacon[8] && m_dmacon[9]) exp_owner = OWN_BITPLANE;
  else if (sprite.req && m_dmacon[5] && m_dmacon[9]) exp_owner = OWN_SPRITE;
  else if (copper.req && m_dmacon[7] && m_dmacon[9]) exp_owner = OWN_COPPER;
  else if (blitter.req && m_dmacon[6] && m_dmacon[9] && !blocked) exp_owner = OWN_BLITTER;
  else exp_owner = OWN_CPU;
  case (exp_owner)
    OWN_DISK:     src = disk;
    OWN_AUDIO:    src = audio;
    OWN_BITPLANE: src = bitplane;
    OWN_SPRITE:   src = sprite;
    OWN_COPPER:   src = copper;
    OWN_BLITTER:  src = blitter;
    default:      src = '0;     // refresh and cpu use address zero
  endcase
  exp_grant.chip_addr  = src.chip_addr;
  exp_grant.reg_addr   = src.reg_addr;
  exp_grant.dbr        = (exp_owner != OWN_CPU);
  exp_grant.dbwe       = src.wr && (exp_owner == OWN_DISK || exp_owner == OWN_BLITTER);
  exp_grant.cpu_custom = (exp_owner == OWN_CPU);
  if (exp_owner == OWN_REFRESH) exp_grant.reg_addr = REG_IDLE;
  if (exp_owner == OWN_CPU) exp_grant.reg_addr = cpu_ra;
  // status word only when dmaconr sits on the register bus
  exp_data = (exp_grant.reg_addr == REG_DMACONR) ? {1'b0, blit_busy, blit_zero, m_dmacon} : '0;
endtask

// state advance at the rising edge, old bltpri counts for the slowdown
task automatic model_update();
  if (!m_slot[0]) begin
    if (!bls || m_dmacon[10]) m_bls_cnt = '0;
    else if (m_bls_cnt != 2'd3) m_bls_cnt = m_bls_cnt + 2'd1;
  end
  if (exp_grant.reg_addr == REG_DMACON) begin
    if (data_in[15]) m_dmacon = m_dmacon | data_in[12:0];
    else m_dmacon = m_dmacon & ~data_in[12:0];
  end
  m_slot = (m_slot == 9'd453) ? 9'd0 : m_slot + 9'd1; // 454 slots per line
endtask

// --------------------
// compare tasks
// --------------------
task automatic check_grant(input bus_grant_t got, input bus_grant_t exp);
  if (got !== exp) begin
    grant_errs++;
    $display("error at %0t: grant got %h exp %h", $time, got, exp);
  end
endtask

task automatic check_owner(input owner_t got, input owner_t exp);
  if (got !== exp) begin
    owner_errs++;
    $display("error at %0t: owner got %s exp %s", $time, got.name(), exp.name());
  end
endtask

task automatic check_ack(input string name, input logic got, input logic exp);
  if (got !== exp) begin
    ack_errs++;
    $display("error at %0t: %s got %b exp %b", $time, name, got, exp);
  end
endtask

task automatic check_data(input word_t got, input word_t exp);
  if (got !== exp) begin
    data_errs++;
    $display("error at %0t: data_out got %h exp %h", $time, got, exp);
  end
endtask

task automatic check_slot(input slot_t got, input slot_t exp);
  if (got !== exp) begin
    slot_errs++;
    $display("error at %0t: slot got %0d exp %0d", $time, got, exp);
  end
endtask

`endif

// ==== verification/tb_agnus_dma.sv ====
// simulation top for the dma slot arbiter with directed dmacon phases and seeded random traffic
`timescale 1ns/100ps

module tb_agnus_dma import dma_arb_pkg::*; ();

  localparam int RANDOM_CYCLES  = 4 * LINE_SLOTS; // four full lines
  localparam int TIMEOUT_CYCLES = 2500;           // random run, directed phases and margin

  logic       clk = 1'b0;
  logic       reset;
  cpu_bus_t   cpu;
  word_t      data_in;
  dma_chan_t  disk;
  dma_chan_t  audio;
  dma_chan_t  bitplane;
  dma_chan_t  sprite;
  dma_chan_t  copper;
  dma_chan_t  blitter;
  logic       blit_busy;
  logic       blit_zero;
  logic       bls;
  bus_grant_t grant;
  owner_t     owner;
  logic       ack_sprite;
  logic       ack_copper;
  logic       ack_blitter;
  word_t      data_out;
  slot_t      slot;
  integer     seed;
  int         cycle_cnt = 0;

  `include "tb_model.svh"

  agnus_dma DUT (.*);

  always #5 clk = ~clk; // 10 ns bus slot

  // hard stop if a phase never completes
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  // --------------------
  // cycle helpers
  // --------------------
  task automatic check_cycle();
    @(negedge clk); // outputs settled mid slot
    model_outputs();
    check_slot(slot, m_slot);
    check_owner(owner, exp_owner);
    check_grant(grant, exp_grant);
    check_ack("ack_sprite", ack_sprite, exp_owner == OWN_SPRITE);
    check_ack("ack_copper", ack_copper, exp_owner == OWN_COPPER);
    check_ack("ack_blitter", ack_blitter, exp_owner == OWN_BLITTER);
    check_data(data_out, exp_data);
  endtask

  task automatic advance();
    @(posedge clk);
    model_update();
    #1; // new inputs land just after the edge
  endtask

  task automatic run_cycle();
    check_cycle();
    advance();
  endtask

  task automatic clear_inputs();
    cpu       = '0;
    data_in   = '0;
    disk      = '0;
    audio     = '0;
    bitplane  = '0;
    sprite    = '0;
    copper    = '0;
    blitter   = '0;
    blit_busy = 1'b0;
    blit_zero = 1'b0;
    bls       = 1'b0;
  endtask

  // cpu register access repeated until the cpu really owned a slot
  task automatic cpu_access(input reg_addr_t addr, input logic wr, input word_t data);
    cpu     = '{aen: 1'b1, rd: !wr, hwr: wr, lwr: wr, addr: addr};
    data_in = data;
    do begin
      run_cycle();
    end while (exp_owner != OWN_CPU);
    cpu = '0;
  endtask

  // blitter ack against a fixed value outside the refresh slots
  task automatic expect_blitter(input logic want);
    check_cycle();
    if (m_slot != 9'd5 && m_slot != 9'd9 && m_slot != 9'd13 && m_slot != 9'd17) begin
      check_ack("ack_blitter", ack_blitter, want);
    end
    advance();
  endtask

  // disk keeps the bus through the next refresh slot
  task automatic disk_over_refresh();
    disk = '{req: 1'b1, chip_addr: 20'h0A5A5, reg_addr: 8'h10, wr: 1'b1};
    while (m_slot != 9'd5 && m_slot != 9'd9 && m_slot != 9'd13 && m_slot != 9'd17) begin
      run_cycle();
    end
    check_cycle();
    check_owner(owner, OWN_DISK);
    advance();
    disk = '0;
  endtask

  task automatic rand_chan(input logic [2:0] thresh, output dma_chan_t c);
    logic [31:0] r1;
    logic [31:0] r2;
    r1          = $random(seed);
    r2          = $random(seed);
    c.req       = (r1[2:0] < thresh); // thresh in eighths
    c.reg_addr  = r1[10:3];
    c.wr        = r1[11];
    c.chip_addr = r2[19:0];
  endtask

  task automatic randomize_inputs();
    logic [31:0] r;
    rand_chan(3'd1, disk);
    rand_chan(3'd2, audio);
    rand_chan(3'd4, bitplane);
    rand_chan(3'd4, sprite);
    rand_chan(3'd4, copper);
    rand_chan(3'd5, blitter);
    r        = $random(seed);
    cpu.aen  = r[0] | r[1];
    cpu.rd   = r[2];
    cpu.hwr  = r[3];
    cpu.lwr  = r[4];
    cpu.addr = (r[7:5] == 3'd0) ? (r[8] ? REG_DMACON : REG_DMACONR) : r[16:9];
    r         = $random(seed);
    data_in   = r[15:0];
    bls       = r[16] | r[17]; // mostly high so the slowdown saturates now and then
    blit_busy = r[18];
    blit_zero = r[19];
  endtask

  // --------------------
  // test sequence
  // --------------------
  initial begin
    seed = 49500;
    reset = 1'b1;
    clear_inputs();
    model_reset();
    repeat (5) @(posedge clk);
    #1 reset = 1'b0;

    // gated channels idle while dmacon is zero
    sprite.req   = 1'b1;
    copper.req   = 1'b1;
    blitter.req  = 1'b1;
    bitplane.req = 1'b1;
    blit_busy    = 1'b1;
    blit_zero    = 1'b1;
    repeat (4) run_cycle();
    clear_inputs();
    blit_busy = 1'b1;
    blit_zero = 1'b1;
    cpu_access(REG_DMACONR, 1'b0, 16'h0000);
    disk_over_refresh();

    // set all enables, then clear sprite and copper one by one
    cpu_access(REG_DMACON, 1'b1, 16'h83E0);
    cpu_access(REG_DMACONR, 1'b0, 16'h0000);
    sprite.req  = 1'b1;
    copper.req  = 1'b1;
    blitter.req = 1'b1;
    repeat (3) run_cycle();
    clear_inputs();
    cpu_access(REG_DMACON, 1'b1, 16'h0020);
    copper.req  = 1'b1;
    blitter.req = 1'b1;
    repeat (3) run_cycle();
    clear_inputs();
    cpu_access(REG_DMACON, 1'b1, 16'h0080);
    blitter.req = 1'b1;
    repeat (3) run_cycle();
    clear_inputs();
    cpu_access(REG_DMACONR, 1'b0, 16'h0000);

    // cpu keeps missing the bus so the blitter gets locked out
    blitter.req = 1'b1;
    bls         = 1'b1;
    repeat (10) run_cycle();
    expect_blitter(1'b0);
    bls = 1'b0;
    repeat (3) run_cycle();
    clear_inputs();
    cpu_access(REG_DMACON, 1'b1, 16'h8400); // bltpri on
    blitter.req = 1'b1;
    bls         = 1'b1;
    repeat (10) run_cycle();
    expect_blitter(1'b1);
    clear_inputs();

    // random traffic over four lines
    repeat (RANDOM_CYCLES) begin
      randomize_inputs();
      run_cycle();
    end

    $display("errors: grant %0d owner %0d ack %0d data %0d slot %0d",
             grant_errs, owner_errs, ack_errs, data_errs, slot_errs);
    if (grant_errs + owner_errs + ack_errs + data_errs + slot_errs == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// ==== files.f ====
+incdir+verification
rtl/dma_arb_pkg.sv
rtl/beam_slot_counter.sv
rtl/dma_control_reg.sv
rtl/bus_arbiter.sv
rtl/agnus_dma.sv
verification/tb_agnus_dma.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the dma arbiter testbench with verilator, run it and look for the pass line in the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f files.f --top-module tb_agnus_dma --Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -q "\*\*\* TEST PASSED \*\*\*" sim.log; then
  exit 0
fi
echo "pass line not found in sim.log"
exit 1
